// ==== rtl/fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// number of taps, which is also the size of one coefficient bank
`define FIR_TAPS 16

`define FIR_SAMPLE_W 16
`define FIR_COEF_W 24

// wide enough that a full pass of 16 products never wraps
`define FIR_ACC_W 48

// 256 coefficient words, split into 16 banks of FIR_TAPS words
`define FIR_ROM_AW 8

`endif

// ==== rtl/firPkg.sv ====
`default_nettype none

`include "fir_defines.svh"

package firPkg;

	typedef logic signed [`FIR_SAMPLE_W-1:0] sampleT;

	typedef logic signed [`FIR_COEF_W-1:0] coefT;

	// one product needs 40 bits, so sixteen of them stay well inside 48
	typedef logic signed [`FIR_ACC_W-1:0] accT;

	typedef logic [$clog2(`FIR_TAPS)-1:0] tapIdxT;  // tap k inside a pass

endpackage

`default_nettype wire

// ==== rtl/tapBus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

// one tap operation per cycle, from the sequencer to the datapath
interface tapBus;

	logic valid;                      // a tap is issued in this cycle
	firPkg::tapIdxT tapIdx;
	logic [`FIR_ROM_AW-1:0] romAddr;  // bank in the upper bits, tap in the lower
	logic last;                       // final tap of the pass

	modport control (
		output valid,
		output tapIdx,
		output romAddr,
		output last
	);

	modport buffer (
		input valid,
		input tapIdx
	);

	modport mac (
		input valid,
		input last
	);

endinterface

`default_nettype wire

// ==== rtl/cRom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module cRom (
	input logic clk,
	input logic reset,
	input logic [`FIR_ROM_AW-1:0] addr,
	output firPkg::coefT data
);

	localparam int Depth = 1 << `FIR_ROM_AW;

	firPkg::coefT coefTable [Depth];

	// word k holds ten times k, so bank b tap k reads 10*(16b+k)
	for (genvar i = 0; i < Depth; i++) begin : genFill
		assign coefTable[i] = firPkg::coefT'(i * 10);
	end

	// one registered read every cycle, whether or not a tap is issued
	always_ff @(posedge clk) begin
		if (reset) begin
			data <= '0;
		end else begin
			data <= coefTable[addr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sampleBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module sampleBuffer (
	input logic clk,
	input logic reset,
	input logic write,
	input firPkg::sampleT sampleIn,
	tapBus.buffer tb,
	output firPkg::sampleT sampleOut
);

	firPkg::sampleT history [`FIR_TAPS];
	firPkg::tapIdxT wrPtr;   // slot that the next sample goes into
	firPkg::tapIdxT newest;
	firPkg::tapIdxT rdPtr;

	// the newest sample sits one slot behind the write pointer
	assign newest = wrPtr - firPkg::tapIdxT'(1);

	// tap k looks k samples further back, wrapping around the ring
	assign rdPtr = newest - tb.tapIdx;

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
		end else if (write) begin
			wrPtr <= wrPtr + firPkg::tapIdxT'(1);  // wraps at FIR_TAPS
		end
	end

	// history starts out as silence, so early outputs see zero samples
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				history[i] <= '0;
			end
		end else if (write) begin
			history[wrPtr] <= sampleIn;
		end
	end

	// registered read lines up with the ROM word of the same tap
	always_ff @(posedge clk) begin
		if (reset) begin
			sampleOut <= '0;
		end else if (tb.valid) begin
			sampleOut <= history[rdPtr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/macUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module macUnit (
	input logic clk,
	input logic reset,
	tapBus.mac tb,
	input firPkg::sampleT sample,
	input firPkg::coefT coef,
	output logic outStrobe,
	output firPkg::accT dataOut
);

	logic validD;            // operands of a tap are present in this cycle
	logic lastD;
	logic fresh;             // next aligned tap opens a new pass
	firPkg::accT product;
	firPkg::accT sum;
	firPkg::accT acc;

	// buffer and ROM both register, so operands trail the tap by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			validD <= 1'b0;
			lastD <= 1'b0;
		end else begin
			validD <= tb.valid;
			lastD <= tb.last;
		end
	end

	// both operands are sign extended before the multiply
	assign product = firPkg::accT'(sample) * firPkg::accT'(coef);

	// the first tap loads, so the previous pass never leaks into this one
	assign sum = fresh ? product : acc + product;

	always_ff @(posedge clk) begin
		if (reset) begin
			fresh <= 1'b1;
		end else if (validD) begin
			fresh <= lastD;
		end
	end

	always_ff @(posedge clk) begin
		if (validD) begin
			acc <= sum;
		end
	end

	// the last product goes straight into the result register
	always_ff @(posedge clk) begin
		if (reset) begin
			outStrobe <= 1'b0;
			dataOut <= '0;
		end else begin
			outStrobe <= lastD;
			if (lastD) begin
				dataOut <= sum;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/firControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module firControl (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [3:0] coefBank,
	output logic overrun,
	output logic busy,
	tapBus.control tb
);

	// taps fill the first FIR_TAPS counts, the last two cover the MAC pipeline
	localparam int PassLen = `FIR_TAPS + 2;
	localparam int CntW = $clog2(PassLen);

	logic running;           // low means idle and ready for a sample
	logic [CntW-1:0] cnt;
	logic [3:0] bank;
	logic accept;
	logic passDone;
	logic tapPhase;
	firPkg::tapIdxT tapIdx;

	assign accept = inStrobe && !running;
	assign passDone = running && (cnt == CntW'(PassLen - 1));
	assign tapPhase = running && (cnt < CntW'(`FIR_TAPS));
	assign tapIdx = firPkg::tapIdxT'(cnt);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			cnt <= '0;
		end else if (accept) begin
			running <= 1'b1;
			cnt <= '0;
		end else if (passDone) begin
			running <= 1'b0;  // result leaves the MAC in this same cycle
		end else if (running) begin
			cnt <= cnt + 1'b1;
		end
	end

	// the bank is held for the whole pass, later changes wait for the next sample
	always_ff @(posedge clk) begin
		if (reset) begin
			bank <= '0;
		end else if (accept) begin
			bank <= coefBank;
		end
	end

	// a strobe during a pass is dropped and reported one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			overrun <= 1'b0;
		end else begin
			overrun <= inStrobe && running;
		end
	end

	assign busy = running;

	assign tb.valid = tapPhase;
	assign tb.tapIdx = tapIdx;
	assign tb.last = tapPhase && (cnt == CntW'(`FIR_TAPS - 1));
	assign tb.romAddr = {bank, tapIdx};  // bank selects 16 consecutive words

endmodule

`default_nettype wire

// ==== rtl/firTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module firTop (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [`FIR_SAMPLE_W-1:0] sampleIn,
	input logic [3:0] coefBank,
	output logic outStrobe,
	output logic [`FIR_ACC_W-1:0] dataOut,
	output logic overrun,
	output logic busy
);

	tapBus tb ();

	firPkg::sampleT tapSample;
	firPkg::coefT tapCoef;
	logic bufWrite;

	// only a sample that control takes may enter the history
	assign bufWrite = inStrobe && !busy;

	firControl control_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.coefBank(coefBank),
		.overrun(overrun),
		.busy(busy),
		.tb(tb.control)
	);

	sampleBuffer buffer_i (
		.clk(clk),
		.reset(reset),
		.write(bufWrite),
		.sampleIn(sampleIn),
		.tb(tb.buffer),
		.sampleOut(tapSample)
	);

	// the ROM only needs the address, so it stays off the bus
	cRom rom_i (
		.clk(clk),
		.reset(reset),
		.addr(tb.romAddr),
		.data(tapCoef)
	);

	macUnit mac_i (
		.clk(clk),
		.reset(reset),
		.tb(tb.mac),
		.sample(tapSample),
		.coef(tapCoef),
		.outStrobe(outStrobe),
		.dataOut(dataOut)
	);

endmodule

`default_nettype wire

// ==== test/firTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module firTb;

	localparam int Timeout = 40;             // cycles allowed for any wait
	localparam int Latency = `FIR_TAPS + 2;  // strobe cycle to outStrobe cycle
	localparam int OverrunGap = 5;
	localparam int ResetCycles = 5;

	logic clk;
	logic reset;
	logic inStrobe;
	firPkg::sampleT sampleIn;
	logic [3:0] coefBank;
	logic outStrobe;
	firPkg::accT dataOut;
	logic overrun;
	logic busy;

	int errorCount;
	logic [31:0] rngState;

	firTop dut_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.sampleIn(sampleIn),
		.coefBank(coefBank),
		.outStrobe(outStrobe),
		.dataOut(dataOut),
		.overrun(overrun),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// inputs change and outputs are read 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic checkQuiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			tick();
			if (outStrobe !== 1'b0) begin
				$display("CHECK FAILED outStrobe: got %h expected 0", outStrobe);
				errorCount++;
			end
			if (overrun !== 1'b0) begin
				$display("CHECK FAILED overrun: got %h expected 0", overrun);
				errorCount++;
			end
		end
	endtask

	// a strobe held during reset must leave no trace in the history
	task automatic resetDut(input logic strobeDuring);
		reset = 1'b1;
		inStrobe = strobeDuring;
		sampleIn = 16'sh7fff;
		checkQuiet(ResetCycles);
		reset = 1'b0;
		inStrobe = 1'b0;
		sampleIn = '0;
	endtask

	task automatic runSample(
		input firPkg::sampleT sample,
		input logic [3:0] bank,
		input firPkg::accT expected,
		input logic probe
	);
		int cycle;
		logic seen;
		logic overrunExp;
		seen = 1'b0;
		cycle = 0;
		if (busy !== 1'b0) begin
			$display("CHECK FAILED busy: got %h expected 0", busy);
			errorCount++;
		end
		sampleIn = sample;
		coefBank = bank;
		inStrobe = 1'b1;
		while (!seen && cycle < Timeout) begin
			tick();
			cycle++;
			inStrobe = 1'b0;
			coefBank = ~bank;  // the pass keeps the bank that came with its sample
			if (probe && cycle == OverrunGap) begin
				// a second sample this early must never reach the history
				rngState = nextRandom(rngState);
				sampleIn = rngState[15:0];
				inStrobe = 1'b1;
			end
			if (cycle <= Latency && busy !== 1'b1) begin
				$display("CHECK FAILED busy: got %h expected 1", busy);
				errorCount++;
			end
			overrunExp = probe && (cycle == OverrunGap + 1);
			if (overrun !== overrunExp) begin
				$display("CHECK FAILED overrun: got %h expected %h", overrun, overrunExp);
				errorCount++;
			end
			if (outStrobe === 1'b1) begin
				seen = 1'b1;
				if (cycle != Latency) begin
					$display("outStrobe came %0d cycles after the sample strobe, not %0d",
						cycle, Latency);
					errorCount++;
				end
				if (dataOut !== expected) begin
					$display("CHECK FAILED dataOut: got %h expected %h", dataOut, expected);
					errorCount++;
				end
			end
		end
		if (!seen) begin
			$display("timeout: no outStrobe within %0d cycles of the sample strobe", Timeout);
			errorCount++;
		end
		checkQuiet(probe ? Latency + 2 : 1);  // a dropped sample must give no second result
	endtask

	initial begin
		int fd;
		int fields;
		int testCount;
		int passCount;
		int startErrors;
		string line;
		logic [7:0] cmd;
		logic [15:0] sampleVal;
		logic [3:0] bankVal;
		logic [47:0] expectVal;
		reset = 1'b1;
		inStrobe = 1'b0;
		sampleIn = '0;
		coefBank = '0;
		errorCount = 0;
		testCount = 0;
		passCount = 0;
		rngState = 32'd29;
		resetDut(1'b0);
		fd = $fopen("test/firTests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file test/firTests.txt");
			errorCount++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%c %h %h %h", cmd, sampleVal, bankVal, expectVal);
					startErrors = errorCount;
					if (fields != 4) begin
						$display("test file line not understood: %s", line);
						errorCount++;
					end else if (cmd == "S" || cmd == "O") begin
						runSample(sampleVal, bankVal, expectVal, cmd == "O");
					end else if (cmd == "R") begin
						resetDut(1'b1);
						if (dataOut !== expectVal) begin
							$display("CHECK FAILED dataOut: got %h expected %h", dataOut, expectVal);
							errorCount++;
						end
					end else begin
						$display("unknown command %c in the test file", cmd);
						errorCount++;
					end
					testCount++;
					if (errorCount == startErrors) begin
						passCount++;
					end
					$display("test %0d: %c sample %h bank %h expect %h %s", testCount, cmd,
						sampleVal, bankVal, expectVal, errorCount == startErrors ? "ok" : "failed");
				end
			end
			$fclose(fd);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", testCount, passCount,
			testCount - passCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/firPkg.sv
rtl/tapBus.sv
rtl/cRom.sv
rtl/sampleBuffer.sv
rtl/macUnit.sv
rtl/firControl.sv
rtl/firTop.sv
test/firTb.sv

// ==== Makefile ====
TOP = firTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

# the run passes only when the log holds the pass line
sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir -o simFir
	./obj_dir/simFir | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/firTests.txt ====
# columns: command sample bank expected, with S a sample, O a sample followed by a dropped strobe
# and R a reset; sample and expected dataOut in hex, bank 0 to f, ROM word k holds 10*k
# impulse on bank 2 gives the coefficients 320 to 470, then zero
S 0001 2 000000000140
S 0000 2 00000000014a
S 0000 2 000000000154
S 0000 2 00000000015e
S 0000 2 000000000168
S 0000 2 000000000172
S 0000 2 00000000017c
S 0000 2 000000000186
S 0000 2 000000000190
S 0000 2 00000000019a
S 0000 2 0000000001a4
S 0000 2 0000000001ae
S 0000 2 0000000001b8
S 0000 2 0000000001c2
S 0000 2 0000000001cc
S 0000 2 0000000001d6
S 0000 2 000000000000
# constant samples on bank 1
S 0003 1 0000000001e0
S 0003 1 0000000003de
S 0003 1 0000000005fa
# mixed signs, negative sums in two's complement
S fffe 1 000000000514
S 8000 1 ffffffb0055a
# one sample on bank 4, then back to bank 1 over the same history
S 0000 4 fffffebb12c0
S 0000 1 ffffffa605e6
# overrun probe, the next result ignores the dropped sample
O 0005 1 ffffffa1094c
S 0000 1 ffffff9c09c4
# reset clears the history
R 0000 0 000000000000
S 0001 f 000000000960
S 0000 f 00000000096a
S 0000 f 000000000974
S ffff f 00000000001e
